// ==== hdl/wbs_pkg.sv ====
// shared constants, address map and Wishbone bus structs
// for the streaming accumulator

`default_nettype none

package wbs_pkg;

  // bus and stream word
  typedef logic [31:0] word_t;

  //////////////////////////////////////////////////////////////////////
  // stream counts and queue sizing
  //////////////////////////////////////////////////////////////////////

  // channels are paired one to one at the top
  localparam int NUM_ISTREAM = 2;
  localparam int NUM_OSTREAM = 2;

  localparam int QUEUE_DEPTH = 2;

  //////////////////////////////////////////////////////////////////////
  // address map, one 8-byte slot per channel
  //////////////////////////////////////////////////////////////////////

  localparam word_t ISTREAM_BASE = 32'h3000_0000;
  localparam word_t OSTREAM_BASE = ISTREAM_BASE + 32'(NUM_ISTREAM * 8);

  localparam logic [2:0] SLOT_STATUS_OFS = 3'd0;
  localparam logic [2:0] SLOT_DATA_OFS   = 3'd4;

  // host request, sel is carried but not decoded
  typedef struct packed {
    word_t      adr;
    word_t      dat;
    logic [3:0] sel;
    logic       cyc;
    logic       stb;
    logic       we;
  } wb_req_t;

  typedef struct packed {
    logic  ack;
    word_t dat;
  } wb_rsp_t;

endpackage

`default_nettype wire

// ==== hdl/stream_queue.sv ====
// val/rdy FIFO of 32-bit words, circular buffer with depth parameter

`timescale 1ns/1ps
`default_nettype none

module stream_queue #(
  parameter int p_depth = 2
) (
  input  wire logic          clk,
  input  wire logic          reset_i,

  input  wire logic          enq_val_i,
  output logic               enq_rdy_o,
  input  wbs_pkg::word_t     enq_msg_i,

  output logic               deq_val_o,
  input  wire logic          deq_rdy_i,
  output wbs_pkg::word_t     deq_msg_o
);

  wbs_pkg::word_t                  mem [p_depth];
  logic [$clog2(p_depth)-1:0]      wr_ptr;
  logic [$clog2(p_depth)-1:0]      rd_ptr;
  logic [$clog2(p_depth+1)-1:0]    count;

  logic push;
  logic pop;

  // full exactly at p_depth entries, no bypass path
  assign enq_rdy_o = (count != p_depth);
  assign deq_val_o = (count != 0);
  assign deq_msg_o = mem[rd_ptr];

  assign push = enq_val_i && enq_rdy_o;
  assign pop  = deq_val_o && deq_rdy_i;

  // storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= enq_msg_i;
    end
  end

  // pointers and occupancy
  always_ff @(posedge clk) begin
    if (reset_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        if (int'(wr_ptr) == p_depth - 1) begin
          wr_ptr <= '0;
        end else begin
          wr_ptr <= wr_ptr + 1'b1;
        end
      end
      if (pop) begin
        if (int'(rd_ptr) == p_depth - 1) begin
          rd_ptr <= '0;
        end else begin
          rd_ptr <= rd_ptr + 1'b1;
        end
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== hdl/stream_accumulator.sv ====
// running-sum stage, one registered output word per accepted input

`timescale 1ns/1ps
`default_nettype none

module stream_accumulator (
  input  wire logic          clk,
  input  wire logic          reset_i,

  input  wire logic          in_val_i,
  output logic               in_rdy_o,
  input  wbs_pkg::word_t     in_data_i,

  output logic               out_val_o,
  input  wire logic          out_rdy_i,
  output wbs_pkg::word_t     out_data_o
);

  wbs_pkg::word_t sum_q;
  logic           out_val_q;
  logic           accept;

  // take a new word when the output slot is free or draining now
  assign in_rdy_o = !out_val_q || out_rdy_i;
  assign accept   = in_val_i && in_rdy_o;

  // sum wraps modulo 2^32
  always_ff @(posedge clk) begin
    if (reset_i) begin
      sum_q <= '0;
    end else if (accept) begin
      sum_q <= sum_q + in_data_i;
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      out_val_q <= 1'b0;
    end else if (accept) begin
      out_val_q <= 1'b1;
    end else if (out_rdy_i) begin
      out_val_q <= 1'b0;
    end
  end

  assign out_val_o  = out_val_q;
  // output word is the sum after the latest accepted input
  assign out_data_o = sum_q;

endmodule

`default_nettype wire

// ==== hdl/wbs_stream_bridge.sv ====
// Wishbone slave bridge: address decode, input and output stream
// queues per channel, read-data mux

`timescale 1ns/1ps
`default_nettype none

module wbs_stream_bridge (
  input  wire logic                          clk,
  input  wire logic                          reset_i,

  input  wbs_pkg::wb_req_t                   wb_req_i,
  output wbs_pkg::wb_rsp_t                   wb_rsp_o,

  // towards the accumulators
  output logic [wbs_pkg::NUM_ISTREAM-1:0]    istream_val_o,
  input  wire logic [wbs_pkg::NUM_ISTREAM-1:0] istream_rdy_i,
  output wbs_pkg::word_t                     istream_data_o [wbs_pkg::NUM_ISTREAM],

  // back from the accumulators
  input  wire logic [wbs_pkg::NUM_OSTREAM-1:0] ostream_val_i,
  output logic [wbs_pkg::NUM_OSTREAM-1:0]    ostream_rdy_o,
  input  wbs_pkg::word_t                     ostream_data_i [wbs_pkg::NUM_OSTREAM]
);

  ////////////////////////////////////////////////////////////////////
  // address decode
  ////////////////////////////////////////////////////////////////////

  logic           rd_xfer;
  logic           wr_xfer;
  logic           in_hit;
  logic           out_hit;
  logic           ofs_status;
  logic           ofs_data;
  wbs_pkg::word_t in_ofs;
  wbs_pkg::word_t out_ofs;

  logic [wbs_pkg::NUM_ISTREAM-1:0] in_sel;
  logic [wbs_pkg::NUM_OSTREAM-1:0] out_sel;

  assign rd_xfer = wb_req_i.cyc && wb_req_i.stb && !wb_req_i.we;
  assign wr_xfer = wb_req_i.cyc && wb_req_i.stb && wb_req_i.we;

  assign in_hit  = (wb_req_i.adr >= wbs_pkg::ISTREAM_BASE)
                && (wb_req_i.adr <  wbs_pkg::OSTREAM_BASE);
  assign out_hit = (wb_req_i.adr >= wbs_pkg::OSTREAM_BASE)
                && (wb_req_i.adr <  wbs_pkg::OSTREAM_BASE
                                    + 32'(wbs_pkg::NUM_OSTREAM * 8));

  // both bases are 8-byte aligned, so the low bits give the slot offset
  assign ofs_status = (wb_req_i.adr[2:0] == wbs_pkg::SLOT_STATUS_OFS);
  assign ofs_data   = (wb_req_i.adr[2:0] == wbs_pkg::SLOT_DATA_OFS);

  assign in_ofs  = wb_req_i.adr - wbs_pkg::ISTREAM_BASE;
  assign out_ofs = wb_req_i.adr - wbs_pkg::OSTREAM_BASE;

  ////////////////////////////////////////////////////////////////////
  // input queues, one push per data write
  ////////////////////////////////////////////////////////////////////

  logic [wbs_pkg::NUM_ISTREAM-1:0] in_push;
  logic [wbs_pkg::NUM_ISTREAM-1:0] in_space;

  for (genvar k = 0; k < wbs_pkg::NUM_ISTREAM; k++) begin : g_istream
    assign in_sel[k]  = in_hit && (in_ofs[31:3] == 29'(k));
    // write to a full queue is dropped by the queue itself
    assign in_push[k] = wr_xfer && in_sel[k] && ofs_data;

    stream_queue #(
      .p_depth (wbs_pkg::QUEUE_DEPTH)
    ) u_iqueue (
      .clk       (clk),
      .reset_i   (reset_i),
      .enq_val_i (in_push[k]),
      .enq_rdy_o (in_space[k]),
      .enq_msg_i (wb_req_i.dat),
      .deq_val_o (istream_val_o[k]),
      .deq_rdy_i (istream_rdy_i[k]),
      .deq_msg_o (istream_data_o[k])
    );
  end

  ////////////////////////////////////////////////////////////////////
  // output queues, one pop per data read
  ////////////////////////////////////////////////////////////////////

  logic [wbs_pkg::NUM_OSTREAM-1:0] out_pop;
  logic [wbs_pkg::NUM_OSTREAM-1:0] out_avail;
  wbs_pkg::word_t                  out_head [wbs_pkg::NUM_OSTREAM];

  for (genvar k = 0; k < wbs_pkg::NUM_OSTREAM; k++) begin : g_ostream
    assign out_sel[k] = out_hit && (out_ofs[31:3] == 29'(k));
    assign out_pop[k] = rd_xfer && out_sel[k] && ofs_data;

    stream_queue #(
      .p_depth (wbs_pkg::QUEUE_DEPTH)
    ) u_oqueue (
      .clk       (clk),
      .reset_i   (reset_i),
      .enq_val_i (ostream_val_i[k]),
      .enq_rdy_o (ostream_rdy_o[k]),
      .enq_msg_i (ostream_data_i[k]),
      .deq_val_o (out_avail[k]),
      .deq_rdy_i (out_pop[k]),
      .deq_msg_o (out_head[k])
    );
  end

  ////////////////////////////////////////////////////////////////////
  // response
  ////////////////////////////////////////////////////////////////////

  // zero for unmapped space and for input-data reads
  always_comb begin
    wb_rsp_o.dat = '0;
    if (rd_xfer) begin
      for (int k = 0; k < wbs_pkg::NUM_ISTREAM; k++) begin
        if (in_sel[k] && ofs_status) begin
          wb_rsp_o.dat = {31'b0, in_space[k]};
        end
      end
      for (int k = 0; k < wbs_pkg::NUM_OSTREAM; k++) begin
        if (out_sel[k] && ofs_status) begin
          wb_rsp_o.dat = {31'b0, out_avail[k]};
        end else if (out_sel[k] && ofs_data) begin
          wb_rsp_o.dat = out_head[k];
        end
      end
    end
  end

  // single-cycle transfers
  assign wb_rsp_o.ack = wb_req_i.cyc && wb_req_i.stb;

endmodule

`default_nettype wire

// ==== hdl/wbs_accel_top.sv ====
// accelerator top: Wishbone bridge plus one accumulator per channel

`timescale 1ns/1ps
`default_nettype none

module wbs_accel_top (
  input  wire logic          clk,
  input  wire logic          reset_i,
  input  wbs_pkg::wb_req_t   wb_req_i,
  output wbs_pkg::wb_rsp_t   wb_rsp_o
);

  // bridge to accumulator
  logic [wbs_pkg::NUM_ISTREAM-1:0] istream_val;
  logic [wbs_pkg::NUM_ISTREAM-1:0] istream_rdy;
  wbs_pkg::word_t                  istream_data [wbs_pkg::NUM_ISTREAM];

  // accumulator to bridge
  logic [wbs_pkg::NUM_OSTREAM-1:0] ostream_val;
  logic [wbs_pkg::NUM_OSTREAM-1:0] ostream_rdy;
  wbs_pkg::word_t                  ostream_data [wbs_pkg::NUM_OSTREAM];

  wbs_stream_bridge u_bridge (
    .clk            (clk),
    .reset_i        (reset_i),
    .wb_req_i       (wb_req_i),
    .wb_rsp_o       (wb_rsp_o),
    .istream_val_o  (istream_val),
    .istream_rdy_i  (istream_rdy),
    .istream_data_o (istream_data),
    .ostream_val_i  (ostream_val),
    .ostream_rdy_o  (ostream_rdy),
    .ostream_data_i (ostream_data)
  );

  // channel k in feeds channel k out
  for (genvar k = 0; k < wbs_pkg::NUM_ISTREAM; k++) begin : g_accum
    stream_accumulator u_accum (
      .clk        (clk),
      .reset_i    (reset_i),
      .in_val_i   (istream_val[k]),
      .in_rdy_o   (istream_rdy[k]),
      .in_data_i  (istream_data[k]),
      .out_val_o  (ostream_val[k]),
      .out_rdy_i  (ostream_rdy[k]),
      .out_data_o (ostream_data[k])
    );
  end

endmodule

`default_nettype wire

// ==== tb/wbs_bus_tasks.svh ====
// Wishbone bus tasks: single write, single read, status poll
// and slot address helpers, included inside the testbench module

`ifndef WBS_BUS_TASKS_SVH
`define WBS_BUS_TASKS_SVH

function automatic wbs_pkg::word_t in_status_adr(input int k);
  return wbs_pkg::ISTREAM_BASE + 32'(8 * k) + 32'(wbs_pkg::SLOT_STATUS_OFS);
endfunction

function automatic wbs_pkg::word_t in_data_adr(input int k);
  return wbs_pkg::ISTREAM_BASE + 32'(8 * k) + 32'(wbs_pkg::SLOT_DATA_OFS);
endfunction

function automatic wbs_pkg::word_t out_status_adr(input int k);
  return wbs_pkg::OSTREAM_BASE + 32'(8 * k) + 32'(wbs_pkg::SLOT_STATUS_OFS);
endfunction

function automatic wbs_pkg::word_t out_data_adr(input int k);
  return wbs_pkg::OSTREAM_BASE + 32'(8 * k) + 32'(wbs_pkg::SLOT_DATA_OFS);
endfunction

// one single-cycle transfer, read data sampled on the falling edge
task automatic bus_xfer(input logic we, input wbs_pkg::word_t adr,
                        input wbs_pkg::word_t wdat, output wbs_pkg::word_t rdat);
  int waited;
  waited = 0;
  @(posedge clk);
  wb_req.adr <= adr;
  wb_req.dat <= wdat;
  wb_req.sel <= 4'hf;
  wb_req.we  <= we;
  wb_req.cyc <= 1'b1;
  wb_req.stb <= 1'b1;
  @(negedge clk);
  while (!wb_rsp.ack) begin
    waited++;
    if (waited > 4) begin
      abort_run("no acknowledge from the DUT within 4 cycles");
    end
    @(negedge clk);
  end
  rdat = wb_rsp.dat;
  // write or pop lands on this edge
  @(posedge clk);
  wb_req.cyc <= 1'b0;
  wb_req.stb <= 1'b0;
  wb_req.we  <= 1'b0;
endtask

task automatic bus_write(input wbs_pkg::word_t adr, input wbs_pkg::word_t dat);
  wbs_pkg::word_t ignored_dat;
  bus_xfer(1'b1, adr, dat, ignored_dat);
endtask

task automatic bus_read(input wbs_pkg::word_t adr, output wbs_pkg::word_t dat);
  bus_xfer(1'b0, adr, '0, dat);
endtask

// reread a status slot until bit 0 is set
task automatic poll_status(input wbs_pkg::word_t adr);
  wbs_pkg::word_t st;
  int tries;
  tries = 1;
  bus_read(adr, st);
  while (!st[0]) begin
    if (tries >= 50) begin
      abort_run($sformatf("status at 0x%08h still clear after 50 polls", adr));
    end
    tries++;
    bus_read(adr, st);
  end
endtask

`endif

// ==== tb/tb_wbs_accel_top.sv ====
// Wishbone streaming accumulator testbench with clock, reset,
// stimulus sequences, running-sum model and assertions

`timescale 1ns/1ps
`default_nettype none

module tb_wbs_accel_top;

  logic             clk = 1'b0;
  logic             reset_i;
  wbs_pkg::wb_req_t wb_req;
  wbs_pkg::wb_rsp_t wb_rsp;

  // running sum per channel and the sums still owed by the DUT
  wbs_pkg::word_t model_sum [wbs_pkg::NUM_ISTREAM];
  wbs_pkg::word_t pending_sums [$];

  wbs_accel_top DUT (
    .clk      (clk),
    .reset_i  (reset_i),
    .wb_req_i (wb_req),
    .wb_rsp_o (wb_rsp)
  );

  always #4 clk = ~clk;

  task automatic fail_and_stop();
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    fail_and_stop();
  endtask

  task automatic report_mismatch(input string name, input wbs_pkg::word_t exp,
                                 input wbs_pkg::word_t got);
    $display("FAIL %s expected 0x%08h got 0x%08h", name, exp, got);
    fail_and_stop();
  endtask

  // ack is cyc and stb in every cycle
  ack_follows_strobes: assert property (@(posedge clk)
    wb_rsp.ack == (wb_req.cyc && wb_req.stb))
    else report_mismatch("wb_rsp_o.ack", 32'($sampled(wb_req.cyc && wb_req.stb)),
                         32'($sampled(wb_rsp.ack)));

  `include "wbs_bus_tasks.svh"

  task automatic expect_read(input wbs_pkg::word_t adr, input wbs_pkg::word_t exp);
    wbs_pkg::word_t got;
    bus_read(adr, got);
    assert (got == exp) else report_mismatch("wb_rsp_o.dat", exp, got);
  endtask

  task automatic push_word(input int k, input wbs_pkg::word_t w);
    bus_write(in_data_adr(k), w);
    model_sum[k] = model_sum[k] + w;
  endtask

  task automatic check_result(input int k);
    poll_status(out_status_adr(k));
    expect_read(out_data_adr(k), model_sum[k]);
  endtask

  // write with cyc alone and then stb alone, neither is a transfer
  task automatic write_without_transfer(input wbs_pkg::word_t adr);
    @(posedge clk);
    wb_req.adr <= adr;
    wb_req.dat <= $urandom();
    wb_req.sel <= 4'hf;
    wb_req.we  <= 1'b1;
    wb_req.cyc <= 1'b1;
    wb_req.stb <= 1'b0;
    @(posedge clk);
    wb_req.cyc <= 1'b0;
    wb_req.stb <= 1'b1;
    @(posedge clk);
    wb_req.stb <= 1'b0;
    wb_req.we  <= 1'b0;
  endtask

  initial begin
    wbs_pkg::word_t w;
    wbs_pkg::word_t st;
    int accepted;
    void'($urandom(32'h4c35));
    reset_i <= 1'b1;
    wb_req  <= '0;
    foreach (model_sum[k]) model_sum[k] = '0;
    repeat (16) @(posedge clk);
    reset_i <= 1'b0;

    // idle status after reset
    for (int k = 0; k < wbs_pkg::NUM_ISTREAM; k++) begin
      expect_read(in_status_adr(k), 32'd1);
      expect_read(out_status_adr(k), 32'd0);
    end

    // first word comes back unchanged since the sum starts at zero
    for (int k = 0; k < wbs_pkg::NUM_ISTREAM; k++) begin
      push_word(k, $urandom());
      check_result(k);
    end

    // twenty words on channel 0 with large ones forcing a wrap
    for (int i = 0; i < 20; i++) begin
      w = $urandom();
      if (i % 4 == 1) w = w | 32'hf000_0000;
      poll_status(in_status_adr(0));
      push_word(0, w);
      check_result(0);
    end

    //////////////////////////////////////////////////////////////////////
    // back-pressure on channel 1
    //////////////////////////////////////////////////////////////////////
    accepted = 0;
    bus_read(in_status_adr(1), st);
    while (st[0]) begin
      if (accepted > 20) abort_run("channel 1 input status never reported full");
      push_word(1, $urandom());
      pending_sums.push_back(model_sum[1]);
      accepted++;
      bus_read(in_status_adr(1), st);
    end
    assert (accepted == 2 * wbs_pkg::QUEUE_DEPTH + 1)
      else report_mismatch("accepted write count", 32'(2 * wbs_pkg::QUEUE_DEPTH + 1),
                           32'(accepted));
    // this word is lost on the full channel
    bus_write(in_data_adr(1), $urandom());
    while (pending_sums.size() > 0) begin
      poll_status(out_status_adr(1));
      expect_read(out_data_adr(1), pending_sums.pop_front());
    end
    expect_read(out_status_adr(1), 32'd0);

    // a stray word here would show up in the channel 0 sums below
    write_without_transfer(in_data_adr(0));

    // interleaved channels keep separate sums
    for (int i = 0; i < 4; i++) begin
      push_word(0, $urandom());
      push_word(1, $urandom());
      check_result(0);
      check_result(1);
    end
    expect_read(32'h0000_1000, 32'd0);
    expect_read(wbs_pkg::OSTREAM_BASE + 32'(wbs_pkg::NUM_OSTREAM * 8), 32'd0);
    expect_read(in_data_adr(0), 32'd0);

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+tb
hdl/wbs_pkg.sv
hdl/stream_queue.sv
hdl/stream_accumulator.sv
hdl/wbs_stream_bridge.sv
hdl/wbs_accel_top.sv
tb/tb_wbs_accel_top.sv

// ==== Bender.yml ====
package:
  name: wbs_accel

sources:
  # RTL in compile order
  - files:
      - hdl/wbs_pkg.sv
      - hdl/stream_queue.sv
      - hdl/stream_accumulator.sv
      - hdl/wbs_stream_bridge.sv
      - hdl/wbs_accel_top.sv
  # testbench
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/tb_wbs_accel_top.sv
